// File: decode_pkg.sv
`default_nettype none

package decode_pkg;

  localparam int xlen_w     = 32;
  localparam int reg_addr_w = 5;

  typedef logic [reg_addr_w-1:0] reg_idx_t;

  // instruction formats, msb first
  typedef struct packed {
    logic [5:0] op6;
    logic [3:0] op4;
    logic [1:0] op2;
    logic [4:0] op5;
    reg_idx_t   rk;
    reg_idx_t   rj;
    reg_idx_t   rd;
  } fmt_3r_t;

  typedef struct packed {
    logic [5:0]  op6;
    logic [3:0]  op4;
    logic [11:0] si12;
    reg_idx_t    rj;
    reg_idx_t    rd;
  } fmt_2ri12_t;

  typedef struct packed {
    logic [5:0]  op6;
    logic [15:0] si16;
    reg_idx_t    rj;
    reg_idx_t    rd;
  } fmt_2ri16_t;

  typedef struct packed {
    logic [5:0]  op6;
    logic        op1;
    logic [19:0] si20;
    reg_idx_t    rd;
  } fmt_1ri20_t;

  // offset is split, high part sits in the low bits
  typedef struct packed {
    logic [5:0]  op6;
    logic [15:0] offs_lo;
    logic [9:0]  offs_hi;
  } fmt_i26_t;

  typedef union packed {
    fmt_3r_t     r3;
    fmt_2ri12_t  ri12;
    fmt_2ri16_t  ri16;
    fmt_1ri20_t  ri20;
    fmt_i26_t    i26;
    logic [31:0] raw;
  } instr_u;

  // major opcodes
  localparam logic [5:0] op_grp_alu = 6'h00;
  localparam logic [5:0] op_lu12i   = 6'h05;
  localparam logic [5:0] op_pcaddu  = 6'h07;
  localparam logic [5:0] op_grp_mem = 6'h0a;
  localparam logic [5:0] op_jirl    = 6'h13;
  localparam logic [5:0] op_b       = 6'h14;
  localparam logic [5:0] op_bl      = 6'h15;
  localparam logic [5:0] op_beq     = 6'h16;
  localparam logic [5:0] op_bne     = 6'h17;
  localparam logic [5:0] op_blt     = 6'h18;
  localparam logic [5:0] op_bge     = 6'h19;
  localparam logic [5:0] op_bltu    = 6'h1a;
  localparam logic [5:0] op_bgeu    = 6'h1b;

  // alu group, bits 25:22
  localparam logic [3:0] fn4_reg   = 4'h0;
  localparam logic [3:0] fn4_shift = 4'h1;
  localparam logic [3:0] fn_slti   = 4'h8;
  localparam logic [3:0] fn_sltui  = 4'h9;
  localparam logic [3:0] fn_addi   = 4'ha;
  localparam logic [3:0] fn_andi   = 4'hd;
  localparam logic [3:0] fn_ori    = 4'he;
  localparam logic [3:0] fn_xori   = 4'hf;

  // bits 21:20
  localparam logic [1:0] fn2_shift = 2'h0;
  localparam logic [1:0] fn2_reg   = 2'h1;

  // bits 19:15
  localparam logic [4:0] fn_add  = 5'h00;
  localparam logic [4:0] fn_slli = 5'h01;
  localparam logic [4:0] fn_sub  = 5'h02;
  localparam logic [4:0] fn_slt  = 5'h04;
  localparam logic [4:0] fn_sltu = 5'h05;
  localparam logic [4:0] fn_nor  = 5'h08;
  localparam logic [4:0] fn_and  = 5'h09;
  localparam logic [4:0] fn_srli = 5'h09;
  localparam logic [4:0] fn_or   = 5'h0a;
  localparam logic [4:0] fn_xor  = 5'h0b;
  localparam logic [4:0] fn_sll  = 5'h0e;
  localparam logic [4:0] fn_srl  = 5'h0f;
  localparam logic [4:0] fn_sra  = 5'h10;
  localparam logic [4:0] fn_srai = 5'h11;

  // memory group, bits 25:22
  localparam logic [3:0] fn_ld_b  = 4'h0;
  localparam logic [3:0] fn_ld_h  = 4'h1;
  localparam logic [3:0] fn_ld_w  = 4'h2;
  localparam logic [3:0] fn_st_b  = 4'h4;
  localparam logic [3:0] fn_st_h  = 4'h5;
  localparam logic [3:0] fn_st_w  = 4'h6;
  localparam logic [3:0] fn_ld_bu = 4'h8;
  localparam logic [3:0] fn_ld_hu = 4'h9;

  typedef logic [11:0] alu_op_t;

  localparam int alu_add  = 0;
  localparam int alu_sub  = 1;
  localparam int alu_slt  = 2;
  localparam int alu_sltu = 3;
  localparam int alu_and  = 4;
  localparam int alu_nor  = 5;
  localparam int alu_or   = 6;
  localparam int alu_xor  = 7;
  localparam int alu_sll  = 8;
  localparam int alu_srl  = 9;
  localparam int alu_sra  = 10;
  localparam int alu_lui  = 11;

  typedef logic [3:0] mem_mask_t;

  localparam mem_mask_t mask_none = 4'h0;
  localparam mem_mask_t mask_b    = 4'h1;
  localparam mem_mask_t mask_h    = 4'h3;
  localparam mem_mask_t mask_w    = 4'hf;

  // immediate kind codes
  localparam logic [2:0] imm_none = 3'd0;
  localparam logic [2:0] imm_ui5  = 3'd1;
  localparam logic [2:0] imm_si12 = 3'd2;
  localparam logic [2:0] imm_ui12 = 3'd3;
  localparam logic [2:0] imm_si16 = 3'd4;
  localparam logic [2:0] imm_si20 = 3'd5;
  localparam logic [2:0] imm_si26 = 3'd6;

  typedef struct packed {
    logic [xlen_w-1:0] pc;
    instr_u            instr;
    logic              pred_taken;
  } fetch_slot_t;

  typedef struct packed {
    alu_op_t           alu_op;
    mem_mask_t         mem_mask;
    logic              res_from_mem;
    logic              mem_we;
    logic              gr_we;
    reg_idx_t          dest;
    logic [xlen_w-1:0] imm;
    logic              src1_is_pc;
    logic              src2_is_imm;
    logic              src2_is_4;
    logic              is_jump;
    logic              use_rj_value;
    logic              use_less;
    logic              need_less;
    logic              use_zero;
    logic              need_zero;
    logic              is_unsigned;
    reg_idx_t          raddr_j;
    reg_idx_t          raddr_kd;
    logic [xlen_w-1:0] rj_value;
    logic [xlen_w-1:0] rkd_value;
    logic [xlen_w-1:0] pc;
    logic              pred_taken;
  } decoded_t;

  typedef struct packed {
    logic     gr_we;
    reg_idx_t dest;
    logic     use_rj;
    logic     use_rkd;
    reg_idx_t raddr_j;
    reg_idx_t raddr_kd;
    logic     is_jump;
  } hazard_info_t;

endpackage

`default_nettype wire

// File: imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

module imm_gen (
  input  wire decode_pkg::instr_u       instr,
  input  wire [2:0]                     kind,
  output logic [decode_pkg::xlen_w-1:0] imm
);

  import decode_pkg::*;

  always_comb begin
    case (kind)
      imm_ui5:  imm = {27'b0, instr.r3.rk};
      imm_si12: imm = {{20{instr.ri12.si12[11]}}, instr.ri12.si12};
      imm_ui12: imm = {20'b0, instr.ri12.si12};
      // branch and jirl offsets, word aligned
      imm_si16: imm = {{14{instr.ri16.si16[15]}}, instr.ri16.si16, 2'b00};
      imm_si20: imm = {instr.ri20.si20, 12'b0};
      imm_si26: begin
        imm = {{4{instr.i26.offs_hi[9]}}, instr.i26.offs_hi, instr.i26.offs_lo, 2'b00};
      end
      default:  imm = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: opcode_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module opcode_decoder (
  input  wire                            clk,
  input  wire                            rst,
  input  wire decode_pkg::fetch_slot_t   slot,
  input  wire [decode_pkg::xlen_w-1:0]   rdata_j,
  input  wire [decode_pkg::xlen_w-1:0]   rdata_kd,
  output decode_pkg::reg_idx_t           raddr_j,
  output decode_pkg::reg_idx_t           raddr_kd,
  output decode_pkg::decoded_t           dec,
  output decode_pkg::hazard_info_t       hz
);

  import decode_pkg::*;

  instr_u            ins;
  logic [5:0]        op6;
  logic [3:0]        op4;
  logic [1:0]        op2;
  logic [4:0]        op5;
  logic              is_alu, is_reg, is_sh_i, is_mem;
  logic              inst_add, inst_sub, inst_slt, inst_sltu, inst_nor, inst_and, inst_or;
  logic              inst_xor, inst_sll, inst_srl, inst_sra, inst_slli, inst_srli, inst_srai;
  logic              inst_addi, inst_slti, inst_sltui, inst_andi, inst_ori, inst_xori;
  logic              inst_ld_b, inst_ld_h, inst_ld_w, inst_ld_bu, inst_ld_hu;
  logic              inst_st_b, inst_st_h, inst_st_w;
  logic              inst_jirl, inst_b, inst_bl, inst_beq, inst_bne;
  logic              inst_blt, inst_bge, inst_bltu, inst_bgeu, inst_lu12i, inst_pcaddu;
  logic              reg_op, imm_op, is_load, is_store, is_cond_br, is_jump, inst_valid;
  logic              kd_is_rd, src1_is_pc, src2_is_imm, src2_is_4, gr_we, use_rj, use_rkd;
  logic [2:0]        imm_kind;
  logic [xlen_w-1:0] imm;
  reg_idx_t          dest;
  alu_op_t           alu_op;
  mem_mask_t         mem_mask;

  assign ins = slot.instr;
  assign op6 = ins.r3.op6;
  assign op4 = ins.r3.op4;
  assign op2 = ins.r3.op2;
  assign op5 = ins.r3.op5;

  assign is_alu  = (op6 == op_grp_alu);
  assign is_reg  = is_alu && (op4 == fn4_reg) && (op2 == fn2_reg);
  assign is_sh_i = is_alu && (op4 == fn4_shift) && (op2 == fn2_shift);
  assign is_mem  = (op6 == op_grp_mem);

  // three-register ops
  assign inst_add  = is_reg && (op5 == fn_add);
  assign inst_sub  = is_reg && (op5 == fn_sub);
  assign inst_slt  = is_reg && (op5 == fn_slt);
  assign inst_sltu = is_reg && (op5 == fn_sltu);
  assign inst_nor  = is_reg && (op5 == fn_nor);
  assign inst_and  = is_reg && (op5 == fn_and);
  assign inst_or   = is_reg && (op5 == fn_or);
  assign inst_xor  = is_reg && (op5 == fn_xor);
  assign inst_sll  = is_reg && (op5 == fn_sll);
  assign inst_srl  = is_reg && (op5 == fn_srl);
  assign inst_sra  = is_reg && (op5 == fn_sra);
  assign inst_slli = is_sh_i && (op5 == fn_slli);
  assign inst_srli = is_sh_i && (op5 == fn_srli);
  assign inst_srai = is_sh_i && (op5 == fn_srai);

  assign inst_addi  = is_alu && (op4 == fn_addi);
  assign inst_slti  = is_alu && (op4 == fn_slti);
  assign inst_sltui = is_alu && (op4 == fn_sltui);
  assign inst_andi  = is_alu && (op4 == fn_andi);
  assign inst_ori   = is_alu && (op4 == fn_ori);
  assign inst_xori  = is_alu && (op4 == fn_xori);

  assign inst_ld_b  = is_mem && (op4 == fn_ld_b);
  assign inst_ld_h  = is_mem && (op4 == fn_ld_h);
  assign inst_ld_w  = is_mem && (op4 == fn_ld_w);
  assign inst_ld_bu = is_mem && (op4 == fn_ld_bu);
  assign inst_ld_hu = is_mem && (op4 == fn_ld_hu);
  assign inst_st_b  = is_mem && (op4 == fn_st_b);
  assign inst_st_h  = is_mem && (op4 == fn_st_h);
  assign inst_st_w  = is_mem && (op4 == fn_st_w);

  assign inst_jirl   = (op6 == op_jirl);
  assign inst_b      = (op6 == op_b);
  assign inst_bl     = (op6 == op_bl);
  assign inst_beq    = (op6 == op_beq);
  assign inst_bne    = (op6 == op_bne);
  assign inst_blt    = (op6 == op_blt);
  assign inst_bge    = (op6 == op_bge);
  assign inst_bltu   = (op6 == op_bltu);
  assign inst_bgeu   = (op6 == op_bgeu);
  assign inst_lu12i  = (op6 == op_lu12i) && !ins.ri20.op1;
  assign inst_pcaddu = (op6 == op_pcaddu) && !ins.ri20.op1;

  assign reg_op = inst_add | inst_sub | inst_slt | inst_sltu | inst_nor | inst_and
                | inst_or | inst_xor | inst_sll | inst_srl | inst_sra;
  assign imm_op = inst_slli | inst_srli | inst_srai | inst_addi | inst_slti | inst_sltui
                | inst_andi | inst_ori | inst_xori;
  assign is_load    = inst_ld_b | inst_ld_h | inst_ld_w | inst_ld_bu | inst_ld_hu;
  assign is_store   = inst_st_b | inst_st_h | inst_st_w;
  assign is_cond_br = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;
  assign is_jump    = is_cond_br | inst_jirl | inst_b | inst_bl;
  assign inst_valid = reg_op | imm_op | is_load | is_store | is_jump | inst_lu12i | inst_pcaddu;

  always_comb begin
    alu_op           = '0;
    alu_op[alu_add]  = inst_add | inst_addi | is_load | is_store | inst_jirl | inst_bl
                     | inst_pcaddu;
    alu_op[alu_sub]  = inst_sub | inst_beq | inst_bne;
    alu_op[alu_slt]  = inst_slt | inst_slti | inst_blt | inst_bge;
    alu_op[alu_sltu] = inst_sltu | inst_sltui | inst_bltu | inst_bgeu;
    alu_op[alu_and]  = inst_and | inst_andi;
    alu_op[alu_nor]  = inst_nor;
    alu_op[alu_or]   = inst_or | inst_ori;
    alu_op[alu_xor]  = inst_xor | inst_xori;
    alu_op[alu_sll]  = inst_sll | inst_slli;
    alu_op[alu_srl]  = inst_srl | inst_srli;
    alu_op[alu_sra]  = inst_sra | inst_srai;
    alu_op[alu_lui]  = inst_lu12i;
  end

  assign mem_mask = (inst_ld_w | inst_st_w) ? mask_w :
                    (inst_ld_h | inst_ld_hu | inst_st_h) ? mask_h :
                    (inst_ld_b | inst_ld_bu | inst_st_b) ? mask_b : mask_none;

  assign imm_kind = (inst_slli | inst_srli | inst_srai) ? imm_ui5 :
                    (inst_addi | inst_slti | inst_sltui | is_load | is_store) ? imm_si12 :
                    (inst_andi | inst_ori | inst_xori) ? imm_ui12 :
                    (inst_jirl | is_cond_br) ? imm_si16 :
                    (inst_lu12i | inst_pcaddu) ? imm_si20 :
                    (inst_b | inst_bl) ? imm_si26 : imm_none;

  imm_gen u_imm (
    .instr (ins),
    .kind  (imm_kind),
    .imm   (imm)
  );

  assign src1_is_pc  = inst_jirl | inst_bl | inst_pcaddu;
  assign src2_is_imm = imm_op | is_load | is_store | inst_lu12i | inst_pcaddu;
  assign src2_is_4   = inst_jirl | inst_bl;

  // stores and compares read rd on the second port
  assign kd_is_rd = is_store | is_cond_br;
  assign raddr_j  = ins.r3.rj;
  assign raddr_kd = kd_is_rd ? ins.r3.rd : ins.r3.rk;

  // unknown encodings fall out with no write
  assign gr_we   = inst_valid & ~is_store & ~is_cond_br & ~inst_b;
  assign dest    = inst_bl ? reg_idx_t'(1) : ins.r3.rd;
  assign use_rj  = inst_valid & ~(inst_b | inst_bl | inst_lu12i | inst_pcaddu);
  assign use_rkd = reg_op | is_store | is_cond_br;

  always_comb begin
    dec.alu_op       = alu_op;
    dec.mem_mask     = mem_mask;
    dec.res_from_mem = is_load;
    dec.mem_we       = is_store;
    dec.gr_we        = gr_we;
    dec.dest         = dest;
    dec.imm          = imm;
    dec.src1_is_pc   = src1_is_pc;
    dec.src2_is_imm  = src2_is_imm;
    dec.src2_is_4    = src2_is_4;
    dec.is_jump      = is_jump;
    dec.use_rj_value = inst_jirl;
    dec.use_less     = inst_blt | inst_bge | inst_bltu | inst_bgeu;
    dec.need_less    = inst_blt | inst_bltu;
    dec.use_zero     = inst_beq | inst_bne;
    dec.need_zero    = inst_beq;
    dec.is_unsigned  = inst_ld_bu | inst_ld_hu;
    dec.raddr_j      = raddr_j;
    dec.raddr_kd     = raddr_kd;
    dec.rj_value     = rdata_j;
    dec.rkd_value    = rdata_kd;
    dec.pc           = slot.pc;
    dec.pred_taken   = slot.pred_taken;
  end

  always_comb begin
    hz.gr_we    = gr_we;
    hz.dest     = dest;
    hz.use_rj   = use_rj;
    hz.use_rkd  = use_rkd;
    hz.raddr_j  = raddr_j;
    hz.raddr_kd = raddr_kd;
    hz.is_jump  = is_jump;
  end

  a_alu_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(alu_op));

endmodule

`default_nettype wire

// File: issue_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module issue_ctrl (
  input  wire                           clk,
  input  wire                           rst,
  input  wire [1:0]                     slot_valid,
  input  wire decode_pkg::hazard_info_t hz0,
  input  wire decode_pkg::hazard_info_t hz1,
  input  wire                           load_en,
  output logic [1:0]                    take
);

  logic raw_j;
  logic raw_kd;
  logic pair_hazard;

  // slot 1 reading what slot 0 writes
  assign raw_j  = hz1.use_rj && (hz1.raddr_j == hz0.dest);
  assign raw_kd = hz1.use_rkd && (hz1.raddr_kd == hz0.dest);

  // r0 writes never split a pair
  assign pair_hazard = hz0.is_jump || (hz0.gr_we && (hz0.dest != '0) && (raw_j || raw_kd));

  assign take[0] = slot_valid[0] && load_en;
  assign take[1] = take[0] && slot_valid[1] && !pair_hazard;

  // fetch buffer fills in order
  a_slot_order: assert property (@(posedge clk) disable iff (rst)
    slot_valid[1] |-> slot_valid[0]);

endmodule

`default_nettype wire

// File: issue_reg.sv
`timescale 1ns/1ps
`default_nettype none

module issue_reg (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        flush,
  input  wire                        out_ready,
  input  wire [1:0]                  take,
  input  wire decode_pkg::decoded_t  dec0,
  input  wire decode_pkg::decoded_t  dec1,
  output logic                       load_en,
  output decode_pkg::decoded_t [1:0] out_bundle,
  output logic [1:0]                 out_valid
);

  // empty slot or execute accepting this cycle
  assign load_en = !flush && (!out_valid[0] || out_ready);

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      out_valid <= 2'b00;
    end else if (load_en) begin
      out_valid <= take;
    end
  end

  always_ff @(posedge clk) begin
    if (load_en) begin
      out_bundle[0] <= dec0;
      out_bundle[1] <= dec1;
    end
  end

  a_hold: assert property (@(posedge clk) disable iff (rst)
    out_valid[0] && !out_ready && !flush |=> $stable(out_bundle) && $stable(out_valid));

  // slot 1 never goes to execute without slot 0
  a_valid_order: assert property (@(posedge clk) disable iff (rst)
    out_valid[1] |-> out_valid[0]);

endmodule

`default_nettype wire

// File: dual_decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module dual_decode_stage (
  input  wire                               clk,
  input  wire                               rst,
  input  wire decode_pkg::fetch_slot_t      slot0,
  input  wire decode_pkg::fetch_slot_t      slot1,
  input  wire [1:0]                         slot_valid,
  output wire [1:0]                         take,
  output wire decode_pkg::reg_idx_t [3:0]   rf_raddr,
  input  wire [3:0][decode_pkg::xlen_w-1:0] rf_rdata,
  output wire decode_pkg::decoded_t [1:0]   out_bundle,
  output wire [1:0]                         out_valid,
  input  wire                               out_ready,
  input  wire                               flush
);

  import decode_pkg::*;

  decoded_t     dec0;
  decoded_t     dec1;
  hazard_info_t hz0;
  hazard_info_t hz1;
  logic         load_en;

  // older slot on read ports 0 and 1
  opcode_decoder u_dec0 (
    .clk      (clk),
    .rst      (rst),
    .slot     (slot0),
    .rdata_j  (rf_rdata[0]),
    .rdata_kd (rf_rdata[1]),
    .raddr_j  (rf_raddr[0]),
    .raddr_kd (rf_raddr[1]),
    .dec      (dec0),
    .hz       (hz0)
  );

  opcode_decoder u_dec1 (
    .clk      (clk),
    .rst      (rst),
    .slot     (slot1),
    .rdata_j  (rf_rdata[2]),
    .rdata_kd (rf_rdata[3]),
    .raddr_j  (rf_raddr[2]),
    .raddr_kd (rf_raddr[3]),
    .dec      (dec1),
    .hz       (hz1)
  );

  issue_ctrl u_issue_ctrl (
    .clk        (clk),
    .rst        (rst),
    .slot_valid (slot_valid),
    .hz0        (hz0),
    .hz1        (hz1),
    .load_en    (load_en),
    .take       (take)
  );

  issue_reg u_issue_reg (
    .clk        (clk),
    .rst        (rst),
    .flush      (flush),
    .out_ready  (out_ready),
    .take       (take),
    .dec0       (dec0),
    .dec1       (dec1),
    .load_en    (load_en),
    .out_bundle (out_bundle),
    .out_valid  (out_valid)
  );

endmodule

`default_nettype wire

// File: decode_model.svh
`ifndef decode_model_svh
`define decode_model_svh

// fetch buffer entry, the slot plus what it should decode to
typedef struct packed {
  fetch_slot_t slot;
  decoded_t    exp;
  logic        use_rj;
  logic        use_rkd;
} fb_entry_t;

typedef struct packed {
  decoded_t   d0;
  decoded_t   d1;
  logic [1:0] v;
} bundle_t;

localparam logic [4:0] reg_fn [11] = '{fn_add, fn_sub, fn_slt, fn_sltu, fn_nor, fn_and,
                                       fn_or, fn_xor, fn_sll, fn_srl, fn_sra};
localparam int reg_alu [11] = '{alu_add, alu_sub, alu_slt, alu_sltu, alu_nor, alu_and,
                                alu_or, alu_xor, alu_sll, alu_srl, alu_sra};
localparam logic [4:0] sh_fn [3] = '{fn_slli, fn_srli, fn_srai};
localparam int sh_alu [3] = '{alu_sll, alu_srl, alu_sra};
localparam logic [3:0] ri_fn [6] = '{fn_addi, fn_slti, fn_sltui, fn_andi, fn_ori, fn_xori};
localparam int ri_alu [6] = '{alu_add, alu_slt, alu_sltu, alu_and, alu_or, alu_xor};
localparam logic [3:0] ld_fn [5] = '{fn_ld_b, fn_ld_h, fn_ld_w, fn_ld_bu, fn_ld_hu};
localparam mem_mask_t ld_mask [5] = '{mask_b, mask_h, mask_w, mask_b, mask_h};
localparam logic [3:0] st_fn [3] = '{fn_st_b, fn_st_h, fn_st_w};
localparam mem_mask_t st_mask [3] = '{mask_b, mask_h, mask_w};
localparam logic [5:0] br_op [6] = '{op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu};

// register file contents, a fixed scramble of the index
function automatic logic [31:0] rf_word(input logic [4:0] idx);
  return (32'h9e37_79b9 * ({27'b0, idx} + 32'd1)) ^ {27'b0, idx};
endfunction

// mostly r0..r3 so that pairs collide often
function automatic logic [4:0] pick_reg();
  logic [31:0] r;
  r = $urandom;
  return (r[7:5] == 3'b000) ? r[4:0] : {3'b000, r[1:0]};
endfunction

function automatic fb_entry_t gen_entry(input logic [31:0] pc);
  fb_entry_t   e;
  logic [31:0] w;
  logic [31:0] r;
  logic [4:0]  rd;
  logic [4:0]  rj;
  logic [4:0]  rk;
  logic        kd_rd;
  int          cls;
  int          sub;
  e = '0;
  kd_rd = 1'b0;
  rd = pick_reg();
  rj = pick_reg();
  rk = pick_reg();
  r = $urandom;
  cls = $urandom_range(0, 10);
  e.use_rj = 1'b1;
  case (cls)
    0: begin
      sub = $urandom_range(0, 10);
      w = {op_grp_alu, fn4_reg, fn2_reg, reg_fn[sub], rk, rj, rd};
      e.exp.alu_op[reg_alu[sub]] = 1'b1;
      e.exp.gr_we = 1'b1;
      e.use_rkd = 1'b1;
    end
    1: begin
      sub = $urandom_range(0, 2);
      w = {op_grp_alu, fn4_shift, fn2_shift, sh_fn[sub], r[4:0], rj, rd};
      e.exp.alu_op[sh_alu[sub]] = 1'b1;
      e.exp.imm = {27'b0, r[4:0]};
      e.exp.src2_is_imm = 1'b1;
      e.exp.gr_we = 1'b1;
    end
    2: begin
      sub = $urandom_range(0, 5);
      w = {op_grp_alu, ri_fn[sub], r[11:0], rj, rd};
      e.exp.alu_op[ri_alu[sub]] = 1'b1;
      // logic ops zero-extend, the others sign-extend
      e.exp.imm = (sub < 3) ? {{20{r[11]}}, r[11:0]} : {20'b0, r[11:0]};
      e.exp.src2_is_imm = 1'b1;
      e.exp.gr_we = 1'b1;
    end
    3: begin
      sub = $urandom_range(0, 4);
      w = {op_grp_mem, ld_fn[sub], r[11:0], rj, rd};
      e.exp.alu_op[alu_add] = 1'b1;
      e.exp.imm = {{20{r[11]}}, r[11:0]};
      e.exp.src2_is_imm = 1'b1;
      e.exp.res_from_mem = 1'b1;
      e.exp.gr_we = 1'b1;
      e.exp.mem_mask = ld_mask[sub];
      e.exp.is_unsigned = (sub >= 3);
    end
    4: begin
      sub = $urandom_range(0, 2);
      w = {op_grp_mem, st_fn[sub], r[11:0], rj, rd};
      e.exp.alu_op[alu_add] = 1'b1;
      e.exp.imm = {{20{r[11]}}, r[11:0]};
      e.exp.src2_is_imm = 1'b1;
      e.exp.mem_we = 1'b1;
      e.exp.mem_mask = st_mask[sub];
      kd_rd = 1'b1;
      e.use_rkd = 1'b1;
    end
    5, 6: begin
      w = {(cls == 5) ? op_lu12i : op_pcaddu, 1'b0, r[19:0], rd};
      e.exp.alu_op[(cls == 5) ? alu_lui : alu_add] = 1'b1;
      e.exp.imm = {r[19:0], 12'b0};
      e.exp.src1_is_pc = (cls == 6);
      e.exp.src2_is_imm = 1'b1;
      e.exp.gr_we = 1'b1;
      e.use_rj = 1'b0;
    end
    7: begin
      w = {op_jirl, r[15:0], rj, rd};
      e.exp.alu_op[alu_add] = 1'b1;
      e.exp.imm = {{14{r[15]}}, r[15:0], 2'b00};
      e.exp.src1_is_pc = 1'b1;
      e.exp.src2_is_4 = 1'b1;
      e.exp.is_jump = 1'b1;
      e.exp.use_rj_value = 1'b1;
      e.exp.gr_we = 1'b1;
    end
    8, 9: begin
      // 26-bit offset, low half in 25:10 and high part in 9:0
      w = {(cls == 8) ? op_b : op_bl, r[15:0], r[25:16]};
      e.exp.imm = {{4{r[25]}}, r[25:0], 2'b00};
      e.exp.is_jump = 1'b1;
      e.exp.alu_op[alu_add] = (cls == 9);
      e.exp.src1_is_pc = (cls == 9);
      e.exp.src2_is_4 = (cls == 9);
      e.exp.gr_we = (cls == 9);
      e.use_rj = 1'b0;
    end
    default: begin
      sub = $urandom_range(0, 5);
      w = {br_op[sub], r[15:0], rj, rd};
      e.exp.alu_op[(sub < 2) ? alu_sub : (sub < 4) ? alu_slt : alu_sltu] = 1'b1;
      e.exp.imm = {{14{r[15]}}, r[15:0], 2'b00};
      e.exp.is_jump = 1'b1;
      e.exp.use_less = (sub >= 2);
      e.exp.need_less = (sub == 2) || (sub == 4);
      e.exp.use_zero = (sub < 2);
      e.exp.need_zero = (sub == 0);
      kd_rd = 1'b1;
      e.use_rkd = 1'b1;
    end
  endcase
  e.exp.raddr_j = w[9:5];
  e.exp.raddr_kd = kd_rd ? w[4:0] : w[14:10];
  // bl links through r1
  e.exp.dest = (cls == 9) ? 5'd1 : w[4:0];
  e.exp.rj_value = rf_word(e.exp.raddr_j);
  e.exp.rkd_value = rf_word(e.exp.raddr_kd);
  e.exp.pc = pc;
  e.exp.pred_taken = r[31];
  e.slot.pc = pc;
  e.slot.instr.raw = w;
  e.slot.pred_taken = r[31];
  return e;
endfunction

// slot 1 must wait behind a jump or a RAW on slot 0's dest
function automatic logic pair_split(input fb_entry_t e0, input fb_entry_t e1);
  logic raw;
  raw = (e1.use_rj && (e1.exp.raddr_j == e0.exp.dest))
     || (e1.use_rkd && (e1.exp.raddr_kd == e0.exp.dest));
  return e0.exp.is_jump || (e0.exp.gr_we && (e0.exp.dest != 5'd0) && raw);
endfunction

`endif

// File: tb_dual_decode.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dual_decode;

  import decode_pkg::*;

  `include "decode_model.svh"

  localparam int n_trans    = 3000;
  localparam int max_cycles = n_trans * 6 + 2000;

  logic                   clk;
  logic                   rst;
  fetch_slot_t            slot0;
  fetch_slot_t            slot1;
  logic [1:0]             slot_valid;
  logic [1:0]             take;
  reg_idx_t [3:0]         rf_raddr;
  logic [3:0][xlen_w-1:0] rf_rdata;
  decoded_t [1:0]         out_bundle;
  logic [1:0]             out_valid;
  logic                   out_ready;
  logic                   flush;

  fb_entry_t   fetch_q[$];
  bundle_t     exp_q[$];
  logic [31:0] next_pc;
  int          errors;
  int          transfers;
  int          duals;
  int          splits;
  int          flushes;
  int          cycles;

  dual_decode_stage UUT (
    .clk        (clk),
    .rst        (rst),
    .slot0      (slot0),
    .slot1      (slot1),
    .slot_valid (slot_valid),
    .take       (take),
    .rf_raddr   (rf_raddr),
    .rf_rdata   (rf_rdata),
    .out_bundle (out_bundle),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .flush      (flush)
  );

  always #5 clk = ~clk;

  // register file answers in the same cycle
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      rf_rdata[i] = rf_word(rf_raddr[i]);
    end
  end

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("CHECK FAILED time %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_dec(input string tag, input decoded_t got, input decoded_t exp);
    check_field({tag, ".alu_op"}, got.alu_op, exp.alu_op);
    check_field({tag, ".mem_mask"}, got.mem_mask, exp.mem_mask);
    check_field({tag, ".res_from_mem"}, got.res_from_mem, exp.res_from_mem);
    check_field({tag, ".mem_we"}, got.mem_we, exp.mem_we);
    check_field({tag, ".gr_we"}, got.gr_we, exp.gr_we);
    check_field({tag, ".dest"}, got.dest, exp.dest);
    check_field({tag, ".imm"}, got.imm, exp.imm);
    check_field({tag, ".src1_is_pc"}, got.src1_is_pc, exp.src1_is_pc);
    check_field({tag, ".src2_is_imm"}, got.src2_is_imm, exp.src2_is_imm);
    check_field({tag, ".src2_is_4"}, got.src2_is_4, exp.src2_is_4);
    check_field({tag, ".is_jump"}, got.is_jump, exp.is_jump);
    check_field({tag, ".use_rj_value"}, got.use_rj_value, exp.use_rj_value);
    check_field({tag, ".use_less"}, got.use_less, exp.use_less);
    check_field({tag, ".need_less"}, got.need_less, exp.need_less);
    check_field({tag, ".use_zero"}, got.use_zero, exp.use_zero);
    check_field({tag, ".need_zero"}, got.need_zero, exp.need_zero);
    check_field({tag, ".is_unsigned"}, got.is_unsigned, exp.is_unsigned);
    check_field({tag, ".raddr_j"}, got.raddr_j, exp.raddr_j);
    check_field({tag, ".raddr_kd"}, got.raddr_kd, exp.raddr_kd);
    check_field({tag, ".rj_value"}, got.rj_value, exp.rj_value);
    check_field({tag, ".rkd_value"}, got.rkd_value, exp.rkd_value);
    check_field({tag, ".pc"}, got.pc, exp.pc);
    check_field({tag, ".pred_taken"}, got.pred_taken, exp.pred_taken);
  endtask

  task automatic refill_fetch();
    while (fetch_q.size() < 4) begin
      fetch_q.push_back(gen_entry(next_pc));
      next_pc += 32'd4;
    end
  endtask

  // runs one cycle from the falling edge
  task automatic run_cycle();
    logic [1:0] exp_ov;
    logic [1:0] exp_take;
    logic       load_en;
    bundle_t    b;
    int         r;
    exp_ov = (exp_q.size() != 0) ? exp_q[0].v : 2'b00;
    check_field("out_valid", out_valid, exp_ov);
    if (exp_ov[0]) compare_dec("out_bundle[0]", out_bundle[0], exp_q[0].d0);
    if (exp_ov[1]) compare_dec("out_bundle[1]", out_bundle[1], exp_q[0].d1);
    r = $urandom_range(0, 9);
    slot_valid = (r == 0) ? 2'b00 : (r < 3) ? 2'b01 : 2'b11;
    out_ready = ($urandom_range(0, 3) != 0);
    flush = ($urandom_range(0, 49) == 0);
    slot0 = fetch_q[0].slot;
    slot1 = fetch_q[1].slot;
    #1;
    check_field("rf_raddr[0]", rf_raddr[0], fetch_q[0].exp.raddr_j);
    check_field("rf_raddr[1]", rf_raddr[1], fetch_q[0].exp.raddr_kd);
    check_field("rf_raddr[2]", rf_raddr[2], fetch_q[1].exp.raddr_j);
    check_field("rf_raddr[3]", rf_raddr[3], fetch_q[1].exp.raddr_kd);
    load_en = !flush && (!exp_ov[0] || out_ready);
    exp_take[0] = slot_valid[0] && load_en;
    exp_take[1] = exp_take[0] && slot_valid[1] && !pair_split(fetch_q[0], fetch_q[1]);
    check_field("take", take, exp_take);
    if (flush && exp_ov[0]) begin
      void'(exp_q.pop_front());
      flushes++;
    end else if (exp_ov[0] && out_ready) begin
      void'(exp_q.pop_front());
      transfers++;
    end
    if (exp_take[0]) begin
      b.d0 = fetch_q[0].exp;
      b.d1 = fetch_q[1].exp;
      b.v = exp_take;
      exp_q.push_back(b);
      void'(fetch_q.pop_front());
      if (exp_take[1]) begin
        void'(fetch_q.pop_front());
        duals++;
      end else if (slot_valid[1]) begin
        splits++;
      end
      refill_fetch();
    end
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("timeout after %0d cycles with %0d transfers, errors %0d",
               cycles, transfers, errors);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'h9842));
    clk = 1'b0;
    rst = 1'b1;
    slot0 = '0;
    slot1 = '0;
    slot_valid = 2'b00;
    out_ready = 1'b0;
    flush = 1'b0;
    errors = 0;
    transfers = 0;
    duals = 0;
    splits = 0;
    flushes = 0;
    cycles = 0;
    next_pc = 32'h1c00_0000;
    refill_fetch();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    while (transfers < n_trans) begin
      run_cycle();
      @(negedge clk);
    end
    // every issue case has to be reached at least once
    assert (duals > 0 && splits > 0 && flushes > 0) else begin
      errors++;
      $display("stimulus missed a case: dual %0d, split %0d, flushed %0d",
               duals, splits, flushes);
    end
    $display("errors %0d, transfers %0d, dual %0d, split %0d, flushed %0d",
             errors, transfers, duals, splits, flushes);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
decode_pkg.sv
imm_gen.sv
opcode_decoder.sv
issue_ctrl.sv
issue_reg.sv
dual_decode_stage.sv
tb_dual_decode.sv

// File: Bender.yml
package:
  name: dual_decode_stage

sources:
  - decode_pkg.sv
  - imm_gen.sv
  - opcode_decoder.sv
  - issue_ctrl.sv
  - issue_reg.sv
  - dual_decode_stage.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_dual_decode.sv
